// ==== flist.f ====
hw/bp_pkg.sv
hw/pht_two_sc.sv
hw/fetch_predict.sv
hw/pred_queue.sv
hw/retire_check.sv
hw/bp_top.sv
verification/bp_checker.sv
verification/tb_bp.sv

// ==== hw/bp_pkg.sv ====
/* shared types of the branch predictor: address width, 2-bit counter encoding,
   fetch request, queue entry, training command, resolve and retire report structs */
package bp_pkg;

	localparam int pc_width = 32;
	localparam int pht_idx_width = 8; // training index, covers up to 256 rows

	// 2-bit saturating counter, the msb is the prediction
	typedef logic [1:0] ctr_t;

	localparam ctr_t ctr_snt = 2'd0; // strongly not taken, reset value
	localparam ctr_t ctr_wnt = 2'd1; // weakly not taken
	localparam ctr_t ctr_wt = 2'd2; // weakly taken
	localparam ctr_t ctr_st = 2'd3; // strongly taken

	// branch presented by fetch, in program order
	typedef struct packed {
		logic [pc_width-1:0] pc;
		logic cond; // conditional branch
		logic ret; // return
	} fetch_req_t;

	// one in-flight prediction waiting for its outcome
	typedef struct packed {
		logic [pc_width-1:0] pc;
		logic pred_valid; // branch was predicted
		logic pred_taken;
	} pred_entry_t;

	// counter training command, valid travels beside it
	typedef struct packed {
		logic [pht_idx_width-1:0] idx;
		logic taken;
	} pht_update_t;

	typedef struct packed {
		logic taken; // actual outcome
	} resolve_t;

	// retire report, one per resolved branch
	typedef struct packed {
		logic [pc_width-1:0] pc;
		logic pred_valid;
		logic pred_taken;
		logic mispredict;
	} result_t;

endpackage

// ==== hw/bp_top.sv ====
/* branch predictor top level: fetch producer, counter table,
   prediction queue and retire consumer */
`timescale 1ns/1ps

module bp_top #(
	parameter int pht_rows = 8,
	parameter int queue_depth = 4
) (
	input logic clock,
	input logic reset,

	input logic fetch_valid,
	input bp_pkg::fetch_req_t fetch_req,
	output logic fetch_ready,

	input logic resolve_valid,
	input bp_pkg::resolve_t resolve,
	output logic resolve_ready,

	output logic result_valid,
	output bp_pkg::result_t result
);

	logic [$clog2(pht_rows)-1:0] lookup_idx;
	logic lookup_taken;

	logic push_valid;
	bp_pkg::pred_entry_t push_entry;
	logic credit_return;

	logic head_valid;
	bp_pkg::pred_entry_t head_entry;
	logic pop;

	logic upd_valid;
	bp_pkg::pht_update_t upd;

	fetch_predict #(
		.pht_rows (pht_rows),
		.queue_depth (queue_depth)
	) i_fetch_predict (
		.clock (clock),
		.reset (reset),
		.fetch_valid (fetch_valid),
		.fetch_req (fetch_req),
		.fetch_ready (fetch_ready),
		.lookup_idx (lookup_idx),
		.lookup_taken (lookup_taken),
		.push_valid (push_valid),
		.push_entry (push_entry),
		.credit_return (credit_return)
	);

	pht_two_sc #(
		.pht_rows (pht_rows)
	) i_pht_two_sc (
		.clock (clock),
		.reset (reset),
		.lookup_idx (lookup_idx),
		.lookup_taken (lookup_taken),
		.upd_valid (upd_valid),
		.upd (upd)
	);

	pred_queue #(
		.queue_depth (queue_depth)
	) i_pred_queue (
		.clock (clock),
		.reset (reset),
		.push_valid (push_valid),
		.push_entry (push_entry),
		.head_valid (head_valid),
		.head_entry (head_entry),
		.pop (pop),
		.credit_return (credit_return)
	);

	retire_check #(
		.pht_rows (pht_rows)
	) i_retire_check (
		.clock (clock),
		.reset (reset),
		.resolve_valid (resolve_valid),
		.resolve (resolve),
		.resolve_ready (resolve_ready),
		.head_valid (head_valid),
		.head_entry (head_entry),
		.pop (pop),
		.upd_valid (upd_valid),
		.upd (upd),
		.result_valid (result_valid),
		.result (result)
	);

endmodule

// ==== hw/fetch_predict.sv ====
/* fetch side producer: credit counter, prediction lookup
   and registered push of queue entries */
`timescale 1ns/1ps

module fetch_predict #(
	parameter int pht_rows = 8,
	parameter int queue_depth = 4
) (
	input logic clock,
	input logic reset,

	input logic fetch_valid,
	input bp_pkg::fetch_req_t fetch_req,
	output logic fetch_ready,

	output logic [$clog2(pht_rows)-1:0] lookup_idx,
	input logic lookup_taken,

	output logic push_valid,
	output bp_pkg::pred_entry_t push_entry,

	input logic credit_return
);

	localparam int idx_w = $clog2(pht_rows);
	localparam int cred_w = $clog2(queue_depth + 1);

	logic [cred_w-1:0] credits; // free queue slots not yet claimed
	logic accept;
	logic predict;

	assign fetch_ready = (credits != '0);
	assign accept = fetch_valid & fetch_ready;

	// word address bits, byte offset dropped
	assign lookup_idx = fetch_req.pc[idx_w+1:2];

	// only conditional non-return branches go through the table
	assign predict = fetch_req.cond & ~fetch_req.ret;

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= cred_w'(queue_depth);
			push_valid <= 1'b0;
		end else begin
			case ({accept, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // both at once cancel out
			endcase
			push_valid <= accept;
		end
	end

	// entry payload, captured on acceptance only
	always_ff @(posedge clock) begin
		if (accept) begin
			push_entry.pc <= fetch_req.pc;
			push_entry.pred_valid <= predict;
			push_entry.pred_taken <= predict & lookup_taken;
		end
	end

	// credits come back from the queue one per pop, never more than issued
	a_credit_bound: assert property (
		@(posedge clock) disable iff (reset)
		credits <= queue_depth
	) else $error("credit count %0d above queue depth", credits);

endmodule

// ==== hw/pht_two_sc.sv ====
/* pattern history table of 2-bit saturating counters
   with lookup port, training port and same-cycle forwarding */
`timescale 1ns/1ps

module pht_two_sc #(
	parameter int pht_rows = 8
) (
	input logic clock,
	input logic reset,

	input logic [$clog2(pht_rows)-1:0] lookup_idx,
	output logic lookup_taken,

	input logic upd_valid,
	input bp_pkg::pht_update_t upd
);

	localparam int idx_w = $clog2(pht_rows);

	bp_pkg::ctr_t [pht_rows-1:0] pht;
	bp_pkg::ctr_t [pht_rows-1:0] next_pht;
	logic [idx_w-1:0] upd_row;

	// one step toward the outcome, saturating at both ends
	function automatic bp_pkg::ctr_t ctr_step(input bp_pkg::ctr_t cur, input logic taken);
		bp_pkg::ctr_t nxt;
		case (cur)
			bp_pkg::ctr_snt: begin
				nxt = taken ? bp_pkg::ctr_wnt : bp_pkg::ctr_snt;
			end
			bp_pkg::ctr_wnt: begin
				nxt = taken ? bp_pkg::ctr_wt : bp_pkg::ctr_snt;
			end
			bp_pkg::ctr_wt: begin
				nxt = taken ? bp_pkg::ctr_st : bp_pkg::ctr_wnt;
			end
			default: begin
				nxt = taken ? bp_pkg::ctr_st : bp_pkg::ctr_wt;
			end
		endcase
		return nxt;
	endfunction

	assign upd_row = upd.idx[idx_w-1:0]; // upper idx bits are zero

	always_comb begin
		next_pht = pht;
		if (upd_valid) begin
			next_pht[upd_row] = ctr_step(pht[upd_row], upd.taken);
		end
	end

	// lookup reads the next state so a training this cycle is already visible
	assign lookup_taken = next_pht[lookup_idx][1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < pht_rows; i++) begin
				pht[i] <= bp_pkg::ctr_snt;
			end
		end else begin
			pht <= next_pht;
		end
	end

	// the retire side must never address a row outside the table
	a_upd_idx_range: assert property (
		@(posedge clock) disable iff (reset)
		upd_valid |-> (upd.idx < pht_rows)
	) else $error("pht update index %0d out of range", upd.idx);

endmodule

// ==== hw/pred_queue.sv ====
/* circular FIFO of in-flight predictions,
   returns one credit to the producer per pop */
`timescale 1ns/1ps

module pred_queue #(
	parameter int queue_depth = 4
) (
	input logic clock,
	input logic reset,

	input logic push_valid,
	input bp_pkg::pred_entry_t push_entry,

	output logic head_valid,
	output bp_pkg::pred_entry_t head_entry,
	input logic pop,

	output logic credit_return
);

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	bp_pkg::pred_entry_t mem [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic full;

	// wrap explicitly, depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(queue_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head_entry = mem[rd_ptr];
	assign full = (count == cnt_w'(queue_depth));

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push_valid) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			case ({push_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_return <= pop; // slot freed, producer may claim it next cycle
		end
	end

	always_ff @(posedge clock) begin
		if (push_valid) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	// producer holds a credit for every push
	a_no_push_full: assert property (
		@(posedge clock) disable iff (reset)
		push_valid |-> !full
	) else $error("push into full prediction queue");

	// consumer only pops behind resolve_ready
	a_no_pop_empty: assert property (
		@(posedge clock) disable iff (reset)
		pop |-> head_valid
	) else $error("pop from empty prediction queue");

endmodule

// ==== hw/retire_check.sv ====
/* retire side consumer: pairs outcomes with the oldest prediction,
   flags mispredictions, trains the table and registers the report */
`timescale 1ns/1ps

module retire_check #(
	parameter int pht_rows = 8
) (
	input logic clock,
	input logic reset,

	input logic resolve_valid,
	input bp_pkg::resolve_t resolve,
	output logic resolve_ready,

	input logic head_valid,
	input bp_pkg::pred_entry_t head_entry,
	output logic pop,

	output logic upd_valid,
	output bp_pkg::pht_update_t upd,

	output logic result_valid,
	output bp_pkg::result_t result
);

	localparam int idx_w = $clog2(pht_rows);

	logic accept;
	logic mispredict;

	// an outcome can only be taken when there is a prediction to match
	assign resolve_ready = head_valid;
	assign accept = resolve_valid & resolve_ready;
	assign pop = accept;

	assign mispredict = head_entry.pred_valid & (head_entry.pred_taken != resolve.taken);

	// unpredicted branches leave the counters alone
	assign upd_valid = accept & head_entry.pred_valid;

	always_comb begin
		upd = '0;
		upd.idx[idx_w-1:0] = head_entry.pc[idx_w+1:2]; // same row as the lookup
		upd.taken = resolve.taken;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= accept;
		end
	end

	// report payload, loaded with the accepted outcome
	always_ff @(posedge clock) begin
		if (accept) begin
			result.pc <= head_entry.pc;
			result.pred_valid <= head_entry.pred_valid;
			result.pred_taken <= head_entry.pred_taken;
			result.mispredict <= mispredict;
		end
	end

endmodule

// ==== verification/bp_checker.sv ====
/* testbench checker: model counter table and prediction queue,
   compares each retire report with the model and the table row */
`timescale 1ns/1ps

module bp_checker #(
	parameter int pht_rows = 8
) (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input bp_pkg::fetch_req_t fetch_req,
	input logic fetch_ready,
	input logic resolve_valid,
	input bp_pkg::resolve_t resolve,
	input logic resolve_ready,
	input logic result_valid,
	input bp_pkg::result_t result,
	input logic check_row, // table expectations ride along with the resolve
	input logic row_pred_taken,
	input logic row_mispredict,
	output int error_count,
	output int compare_count
);

	localparam int idx_w = $clog2(pht_rows);

	logic [1:0] model_ctr [pht_rows];
	bp_pkg::pred_entry_t model_q [$];
	bp_pkg::result_t expected;
	logic expect_result;
	logic expect_row; // also compare with the table
	logic tbl_pred_taken;
	logic tbl_mispredict;

	initial begin
		error_count = 0;
		compare_count = 0;
		expect_result = 1'b0;
	end

	task automatic compare_field(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		compare_count++;
		if (exp_v !== act_v) begin
			$display("error t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
			error_count++;
		end
	endtask

	// sampled mid-cycle, everything from the last edge has settled
	always @(negedge clock) begin
		bp_pkg::pred_entry_t head;
		bp_pkg::pred_entry_t entry;
		int idx;
		if (reset) begin
			for (int i = 0; i < pht_rows; i++) model_ctr[i] = 2'd0;
			model_q.delete();
			expect_result = 1'b0;
		end else begin
			if (expect_result && !result_valid) begin
				$display("result_valid missing at t=%0t after an accepted resolve", $time);
				error_count++;
			end else if (!expect_result && result_valid) begin
				$display("result_valid raised at t=%0t with no resolve accepted", $time);
				error_count++;
			end else if (expect_result) begin
				compare_field("result.pc", expected.pc, result.pc);
				compare_field("result.pred_valid", expected.pred_valid, result.pred_valid);
				compare_field("result.pred_taken", expected.pred_taken, result.pred_taken);
				compare_field("result.mispredict", expected.mispredict, result.mispredict);
				if (expect_row) begin
					compare_field("result.pred_taken (table)", tbl_pred_taken, result.pred_taken);
					compare_field("result.mispredict (table)", tbl_mispredict, result.mispredict);
				end
			end
			expect_result = 1'b0;
			// training goes first so a lookup in the same cycle sees it
			if (resolve_valid && resolve_ready) begin
				if (model_q.size() == 0) begin
					$display("resolve accepted at t=%0t with no branch in flight", $time);
					error_count++;
				end else begin
					head = model_q.pop_front();
					expected.pc = head.pc;
					expected.pred_valid = head.pred_valid;
					expected.pred_taken = head.pred_taken;
					expected.mispredict = head.pred_valid && (head.pred_taken != resolve.taken);
					expect_result = 1'b1;
					expect_row = check_row;
					tbl_pred_taken = row_pred_taken;
					tbl_mispredict = row_mispredict;
					if (head.pred_valid) begin
						idx = head.pc[idx_w+1:2];
						if (resolve.taken && model_ctr[idx] != 2'd3) model_ctr[idx] += 2'd1;
						if (!resolve.taken && model_ctr[idx] != 2'd0) model_ctr[idx] -= 2'd1;
					end
				end
			end
			if (fetch_valid && fetch_ready) begin
				idx = fetch_req.pc[idx_w+1:2];
				entry.pc = fetch_req.pc;
				entry.pred_valid = fetch_req.cond && !fetch_req.ret;
				entry.pred_taken = entry.pred_valid && model_ctr[idx][1]; // upper bit
				model_q.push_back(entry);
			end
		end
	end

endmodule

// ==== verification/tb_bp.sv ====
/* testbench top: clock, reset, directed and random stimulus table,
   row loop, timeout and summary */
`timescale 1ns/1ps

module tb_bp;

	localparam int pht_rows = 8;
	localparam int queue_depth = 4;
	localparam int n_directed = 43;
	localparam int n_random = 40;
	localparam int n_rows = n_directed + n_random;
	localparam int timeout_cycles = n_rows * 6 + 100;

	localparam logic [1:0] k_fetch = 2'd0;
	localparam logic [1:0] k_resolve = 2'd1;
	localparam logic [1:0] k_both = 2'd2; // fetch and resolve in one cycle
	localparam logic [1:0] k_full = 2'd3; // resolve while the queue is full

	// expected fields describe the report of the resolve in the row
	typedef struct packed {
		logic [1:0] kind;
		logic [31:0] pc;
		logic cond;
		logic ret;
		logic taken;
		logic check;
		logic exp_pred_taken;
		logic exp_mispredict;
	} row_t;

	logic clock;
	logic reset;
	logic fetch_valid;
	bp_pkg::fetch_req_t fetch_req;
	logic fetch_ready;
	logic resolve_valid;
	bp_pkg::resolve_t resolve;
	logic resolve_ready;
	logic result_valid;
	bp_pkg::result_t result;
	logic check_row;
	logic row_pred_taken;
	logic row_mispredict;
	int error_count;
	int compare_count;

	row_t rows [n_rows];
	int seed = 44;
	int tb_errors;
	int in_flight; // accepted fetches not yet resolved
	int cycle_count;

	bp_top #(.pht_rows(pht_rows), .queue_depth(queue_depth)) i_bp_top (.*);

	bp_checker #(.pht_rows(pht_rows)) i_checker (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic row_t make_row(input logic [1:0] kind, input logic [31:0] pc,
			input logic cond, input logic ret, input logic taken,
			input logic exp_pred_taken, input logic exp_mispredict);
		return {kind, pc, cond, ret, taken, 1'b1, exp_pred_taken, exp_mispredict};
	endfunction

	task automatic load_directed();
		rows[0] = make_row(k_fetch, 32'h100, 1, 0, 0, 0, 0); // all counters start at 0
		rows[1] = make_row(k_resolve, 0, 0, 0, 0, 0, 0);
		rows[2] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0); // row 2 training
		rows[3] = make_row(k_resolve, 0, 0, 0, 1, 0, 1); // 0 -> 1
		rows[4] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0);
		rows[5] = make_row(k_resolve, 0, 0, 0, 1, 0, 1); // 1 -> 2
		rows[6] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0);
		rows[7] = make_row(k_resolve, 0, 0, 0, 1, 1, 0); // 2 -> 3
		rows[8] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0);
		rows[9] = make_row(k_resolve, 0, 0, 0, 1, 1, 0); // stays at 3
		rows[10] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0); // hysteresis
		rows[11] = make_row(k_resolve, 0, 0, 0, 0, 1, 1); // 3 -> 2
		rows[12] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0);
		rows[13] = make_row(k_resolve, 0, 0, 0, 0, 1, 1); // 2 -> 1
		rows[14] = make_row(k_fetch, 32'h108, 1, 0, 0, 0, 0);
		rows[15] = make_row(k_resolve, 0, 0, 0, 0, 0, 0); // 1 -> 0
		rows[16] = make_row(k_fetch, 32'h10c, 1, 0, 0, 0, 0); // row 3
		rows[17] = make_row(k_resolve, 0, 0, 0, 1, 0, 1); // 0 -> 1
		rows[18] = make_row(k_fetch, 32'h10c, 1, 1, 0, 0, 0); // return
		rows[19] = make_row(k_resolve, 0, 0, 0, 1, 0, 0);
		rows[20] = make_row(k_fetch, 32'h10c, 0, 0, 0, 0, 0); // unconditional
		rows[21] = make_row(k_resolve, 0, 0, 0, 1, 0, 0);
		rows[22] = make_row(k_fetch, 32'h10c, 1, 0, 0, 0, 0); // still 1, not taken
		rows[23] = make_row(k_resolve, 0, 0, 0, 0, 0, 0);
		rows[24] = make_row(k_fetch, 32'h110, 1, 0, 0, 0, 0); // row 4
		rows[25] = make_row(k_resolve, 0, 0, 0, 1, 0, 1);
		rows[26] = make_row(k_fetch, 32'h113, 1, 0, 0, 0, 0); // byte offset differs
		rows[27] = make_row(k_resolve, 0, 0, 0, 1, 0, 1);
		rows[28] = make_row(k_fetch, 32'h2110, 1, 0, 0, 0, 0); // upper bits differ
		rows[29] = make_row(k_resolve, 0, 0, 0, 1, 1, 0);
		rows[30] = make_row(k_fetch, 32'h114, 1, 0, 0, 0, 0); // row 5 untouched
		rows[31] = make_row(k_resolve, 0, 0, 0, 0, 0, 0);
		rows[32] = make_row(k_fetch, 32'h118, 1, 0, 0, 0, 0); // fill the queue
		rows[33] = make_row(k_fetch, 32'h11c, 1, 0, 0, 0, 0);
		rows[34] = make_row(k_fetch, 32'h110, 1, 0, 0, 0, 0); // row 4 at 3
		rows[35] = make_row(k_fetch, 32'h104, 1, 0, 0, 0, 0);
		rows[36] = make_row(k_full, 0, 0, 0, 1, 0, 1); // row 6 -> 1
		rows[37] = make_row(k_resolve, 0, 0, 0, 1, 0, 1);
		rows[38] = make_row(k_resolve, 0, 0, 0, 0, 1, 1);
		rows[39] = make_row(k_resolve, 0, 0, 0, 0, 0, 0);
		rows[40] = make_row(k_fetch, 32'h118, 1, 0, 0, 0, 0); // row 6 at 1
		rows[41] = make_row(k_both, 32'h118, 1, 0, 1, 0, 1); // lookup sees 2
		rows[42] = make_row(k_resolve, 0, 0, 0, 1, 1, 0);
	endtask

	task automatic fill_random(output row_t rw);
		rw = '0;
		rw.pc = $random(seed);
		rw.cond = ({$random(seed)} % 4) != 0; // mostly conditional
		rw.ret = ({$random(seed)} % 8) == 0;
		rw.taken = $random(seed);
		if (in_flight == 0) rw.kind = k_fetch;
		else if (in_flight == queue_depth) rw.kind = k_resolve;
		else rw.kind = {$random(seed)} % 3;
	endtask

	// starts and ends 1 ns after a rising edge
	task automatic apply_row(input int num, input row_t rw);
		logic f_pend;
		logic r_pend;
		logic f_acc;
		logic r_acc;
		int errs_before;
		int wait_cycles;
		errs_before = tb_errors + error_count;
		f_pend = (rw.kind == k_fetch) || (rw.kind == k_both);
		r_pend = (rw.kind != k_fetch);
		if (rw.kind == k_full && fetch_ready !== 1'b0) begin
			$display("error t=%0t fetch_ready expected 0 got %b", $time, fetch_ready);
			tb_errors++;
		end
		while (rw.kind == k_both && !(fetch_ready && resolve_ready)) begin
			@(posedge clock);
			#1;
		end
		fetch_valid = f_pend;
		fetch_req.pc = rw.pc;
		fetch_req.cond = rw.cond;
		fetch_req.ret = rw.ret;
		resolve_valid = r_pend;
		resolve.taken = rw.taken;
		check_row = rw.check;
		row_pred_taken = rw.exp_pred_taken;
		row_mispredict = rw.exp_mispredict;
		while (f_pend || r_pend) begin
			f_acc = fetch_valid && fetch_ready;
			r_acc = resolve_valid && resolve_ready;
			@(posedge clock);
			#1;
			if (f_acc) begin
				fetch_valid = 1'b0;
				f_pend = 1'b0;
				in_flight++;
			end
			if (r_acc) begin
				resolve_valid = 1'b0;
				r_pend = 1'b0;
				in_flight--;
			end
		end
		if (rw.kind == k_full) begin
			wait_cycles = 0;
			while (!fetch_ready && wait_cycles < 3) begin
				@(posedge clock);
				#1;
				wait_cycles++;
			end
			if (wait_cycles > 2) begin
				$display("fetch_ready did not come back within 2 cycles of a resolve");
				tb_errors++;
			end
		end
		@(negedge clock); // checker compares the report here
		#1;
		$display("row %0d kind %0d pc %h: %s", num, rw.kind, rw.pc,
			(tb_errors + error_count == errs_before) ? "ok" : "failed");
		@(posedge clock);
		#1;
	endtask

	initial begin
		row_t rw;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_req = '0;
		resolve_valid = 1'b0;
		resolve = '0;
		check_row = 1'b0;
		row_pred_taken = 1'b0;
		row_mispredict = 1'b0;
		tb_errors = 0;
		in_flight = 0;
		load_directed();
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		if (fetch_ready !== 1'b1 || resolve_ready !== 1'b0) begin
			$display("error t=%0t fetch_ready/resolve_ready expected 1/0 got %b/%b",
				$time, fetch_ready, resolve_ready);
			tb_errors++;
		end
		for (int i = 0; i < n_rows; i++) begin
			if (i >= n_directed) fill_random(rows[i]);
			apply_row(i, rows[i]);
		end
		// drain branches the random rows left in flight
		while (in_flight > 0) begin
			rw = '0;
			rw.kind = k_resolve;
			apply_row(n_rows, rw);
		end
		$display("summary: %0d rows, %0d compares, %0d errors", n_rows, compare_count,
			tb_errors + error_count);
		if (tb_errors + error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
